// File: lsu_sub.f
source/lsu_pkg.sv
source/lsu_align.sv
source/l1d_cache.sv
source/axil_master.sv
source/lsu_ctrl.sv
source/lsu_sub.sv
verif/axil_mem_model.sv
verif/lsu_checker.sv
verif/lsu_tb.sv

// File: run.sh
#!/bin/sh
# build and run the lsu_sub testbench with Verilator
cd "$(dirname "$0")" || exit 1

out=$(verilator --binary --timing --top-module lsu_tb -f lsu_sub.f -o lsu_sim 2>&1 \
  && ./obj_dir/lsu_sim 2>&1) || { echo "$out"; exit 1; }
echo "$out"

echo "$out" | grep -qx "test passed" && exit 0 || exit 1

// File: source/axil_master.sv
`timescale 1ns/1ns
`default_nettype none

module axil_master (
  input  wire                        clk,
  input  wire                        rst_n_i,
  input  wire                        start_i,
  input  wire                        write_i,
  input  wire  [lsu_pkg::ADDR_W-1:0] addr_i,
  input  wire  [lsu_pkg::DATA_W-1:0] wdata_i,
  input  wire  [3:0]                 wstrb_i,
  output logic [lsu_pkg::ADDR_W-1:0] m_awaddr_o,
  output logic                       m_awvalid_o,
  input  wire                        m_awready_i,
  output logic [lsu_pkg::DATA_W-1:0] m_wdata_o,
  output logic [3:0]                 m_wstrb_o,
  output logic                       m_wvalid_o,
  input  wire                        m_wready_i,
  input  wire  [1:0]                 m_bresp_i,
  input  wire                        m_bvalid_i,
  output logic                       m_bready_o,
  output logic [lsu_pkg::ADDR_W-1:0] m_araddr_o,
  output logic                       m_arvalid_o,
  input  wire                        m_arready_i,
  input  wire  [lsu_pkg::DATA_W-1:0] m_rdata_i,
  input  wire  [1:0]                 m_rresp_i,
  input  wire                        m_rvalid_i,
  output logic                       m_rready_o,
  output logic                       done_o,
  output logic [lsu_pkg::DATA_W-1:0] rdata_o,
  output logic                       err_o
);
  import lsu_pkg::*;

  logic [ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0] wdata_q;
  logic [3:0]        wstrb_q;
  logic              awvalid_q;
  logic              wvalid_q;
  logic              bready_q;
  logic              arvalid_q;
  logic              rready_q;
  logic              b_done;
  logic              r_done;

  assign m_awaddr_o  = addr_q;
  assign m_araddr_o  = addr_q;
  assign m_wdata_o   = wdata_q;
  assign m_wstrb_o   = wstrb_q;
  assign m_awvalid_o = awvalid_q;
  assign m_wvalid_o  = wvalid_q;
  assign m_bready_o  = bready_q;
  assign m_arvalid_o = arvalid_q;
  assign m_rready_o  = rready_q;

  assign b_done  = m_bvalid_i && bready_q;
  assign r_done  = m_rvalid_i && rready_q;
  assign done_o  = b_done || r_done;
  assign rdata_o = m_rdata_i;
  assign err_o   = b_done ? (m_bresp_i != AXI_RESP_OKAY) : (m_rresp_i != AXI_RESP_OKAY);

  always_ff @(posedge clk)
  begin
    if (start_i)
    begin
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
      wstrb_q <= wstrb_i;
    end
  end

  // aw and w are raised together, each drops on its own handshake
  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      awvalid_q <= 1'b0;
      wvalid_q  <= 1'b0;
      bready_q  <= 1'b0;
      arvalid_q <= 1'b0;
      rready_q  <= 1'b0;
    end
    else if (start_i)
    begin
      awvalid_q <= write_i;
      wvalid_q  <= write_i;
      bready_q  <= write_i;
      arvalid_q <= !write_i;
      rready_q  <= !write_i;
    end
    else
    begin
      if (m_awready_i)
        awvalid_q <= 1'b0;
      if (m_wready_i)
        wvalid_q <= 1'b0;
      if (b_done)
        bready_q <= 1'b0;
      if (m_arready_i)
        arvalid_q <= 1'b0;
      if (r_done)
        rready_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: source/l1d_cache.sv
`timescale 1ns/1ns
`default_nettype none

module l1d_cache (
  input  wire                        clk,
  input  wire                        rst_n_i,
  input  wire                        enable_i,
  input  wire  [lsu_pkg::ADDR_W-1:0] lookup_addr_i,
  input  wire                        fill_i,
  input  wire  [lsu_pkg::DATA_W-1:0] fill_data_i,
  input  wire                        inval_i,
  output logic                       hit_o,
  output logic [lsu_pkg::DATA_W-1:0] hit_data_o
);
  import lsu_pkg::*;

  logic [L1D_TAG_W-1:0] tag_q [L1D_LINES];
  logic [DATA_W-1:0]    data_q [L1D_LINES];
  logic [L1D_LINES-1:0] valid_q;

  logic [L1D_IDX_W-1:0] idx;
  logic [L1D_TAG_W-1:0] tag;
  logic                 tag_match;

  // word offset is bits 1:0, index above it, tag on top
  assign idx = lookup_addr_i[L1D_IDX_W+1:2];
  assign tag = lookup_addr_i[ADDR_W-1:L1D_IDX_W+2];

  assign tag_match  = valid_q[idx] && (tag_q[idx] == tag);
  assign hit_o      = enable_i && tag_match;
  assign hit_data_o = data_q[idx];

  always_ff @(posedge clk)
  begin
    if (!rst_n_i || !enable_i)
    begin
      valid_q <= '0;
    end
    else if (fill_i)
    begin
      valid_q[idx] <= 1'b1;
    end
    else if (inval_i && tag_match)
    begin
      valid_q[idx] <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (fill_i)
    begin
      tag_q[idx]  <= tag;
      data_q[idx] <= fill_data_i;
    end
  end

endmodule

`default_nettype wire

// File: source/lsu_align.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_align (
  input  wire  [3:0]                 op_i,
  input  wire  [1:0]                 addr_lo_i,
  input  wire  [lsu_pkg::DATA_W-1:0] store_data_i,
  input  wire  [lsu_pkg::DATA_W-1:0] raw_word_i,
  output logic [lsu_pkg::DATA_W-1:0] lane_data_o,
  output logic [3:0]                 strb_o,
  output logic                       misaligned_o,
  output logic [lsu_pkg::DATA_W-1:0] load_data_o
);
  import lsu_pkg::*;

  load_word_u  word;
  logic [7:0]  sel_byte;
  logic [15:0] sel_half;

  assign word     = raw_word_i;
  assign sel_byte = word.b[addr_lo_i];
  assign sel_half = word.h[addr_lo_i[1]];

  always_comb
  begin
    lane_data_o  = store_data_i;
    strb_o       = 4'b0000;
    misaligned_o = 1'b0;
    load_data_o  = raw_word_i;
    case (op_i)
      LSU_OP_LB:  load_data_o = {{24{sel_byte[7]}}, sel_byte};
      LSU_OP_LBU: load_data_o = {24'h0, sel_byte};
      LSU_OP_LH:
      begin
        misaligned_o = addr_lo_i[0];
        load_data_o  = {{16{sel_half[15]}}, sel_half};
      end
      LSU_OP_LHU:
      begin
        misaligned_o = addr_lo_i[0];
        load_data_o  = {16'h0, sel_half};
      end
      LSU_OP_LW:  misaligned_o = (addr_lo_i != 2'b00);
      // byte and halfword copied into every lane, strobe picks one
      LSU_OP_SB:
      begin
        lane_data_o = {4{store_data_i[7:0]}};
        strb_o      = 4'b0001 << addr_lo_i;
      end
      LSU_OP_SH:
      begin
        lane_data_o  = {2{store_data_i[15:0]}};
        strb_o       = addr_lo_i[1] ? 4'b1100 : 4'b0011;
        misaligned_o = addr_lo_i[0];
      end
      LSU_OP_SW:
      begin
        strb_o       = 4'b1111;
        misaligned_o = (addr_lo_i != 2'b00);
      end
      default:    load_data_o = raw_word_i;
    endcase
  end

endmodule

`default_nettype wire

// File: source/lsu_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_ctrl (
  input  wire                        clk,
  input  wire                        rst_n_i,
  input  wire                        req_valid_i,
  output logic                       req_ready_o,
  input  wire  [3:0]                 req_op_i,
  input  wire  [lsu_pkg::ADDR_W-1:0] req_addr_i,
  output logic                       rsp_valid_o,
  input  wire                        rsp_ready_i,
  output logic [lsu_pkg::DATA_W-1:0] rsp_word_o,
  output logic                       rsp_err_o,
  input  wire                        cache_en_i,
  output logic [lsu_pkg::ADDR_W-1:0] lookup_addr_o,
  input  wire                        hit_i,
  input  wire  [lsu_pkg::DATA_W-1:0] hit_data_i,
  output logic                       fill_o,
  output logic                       inval_o,
  input  wire                        misaligned_i,
  output logic [3:0]                 align_op_o,
  output logic [1:0]                 align_addr_lo_o,
  output logic                       bus_start_o,
  output logic                       bus_write_o,
  output logic [lsu_pkg::ADDR_W-1:0] bus_addr_o,
  input  wire                        bus_done_i,
  input  wire  [lsu_pkg::DATA_W-1:0] bus_rdata_i,
  input  wire                        bus_err_i
);
  import lsu_pkg::*;

  logic [1:0]        state_q;
  logic [3:0]        op_q;
  logic [ADDR_W-1:0] addr_q;
  logic              write_q;
  logic [DATA_W-1:0] word_q;
  logic              err_q;
  logic              idle;
  logic              accept;
  logic              req_store;
  logic              req_hit;

  assign idle      = (state_q == CTRL_IDLE);
  assign accept    = req_valid_i && idle;
  assign req_store = (req_op_i == LSU_OP_SB) || (req_op_i == LSU_OP_SH) ||
                     (req_op_i == LSU_OP_SW);
  assign req_hit   = !req_store && cache_en_i && hit_i;

  // request fields straight through while idle, latched afterwards
  assign lookup_addr_o   = idle ? req_addr_i : addr_q;
  assign align_op_o      = idle ? req_op_i : op_q;
  assign align_addr_lo_o = idle ? req_addr_i[1:0] : addr_q[1:0];

  assign bus_start_o = accept && !misaligned_i && !req_hit;
  assign bus_write_o = req_store;
  assign bus_addr_o  = {req_addr_i[ADDR_W-1:2], 2'b00};

  assign inval_o = accept && req_store && !misaligned_i;
  // fill only on a clean read response
  assign fill_o  = (state_q == CTRL_BUS) && bus_done_i && !write_q && !bus_err_i &&
                   cache_en_i;

  assign req_ready_o = idle;
  assign rsp_valid_o = (state_q == CTRL_RESP);
  assign rsp_word_o  = word_q;
  assign rsp_err_o   = err_q;

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      state_q <= CTRL_IDLE;
    end
    else
    begin
      case (state_q)
        CTRL_IDLE:
        begin
          if (accept)
          begin
            if (misaligned_i || req_hit)
              state_q <= CTRL_RESP;
            else
              state_q <= CTRL_BUS;
          end
        end
        CTRL_BUS:
        begin
          if (bus_done_i)
            state_q <= CTRL_RESP;
        end
        CTRL_RESP:
        begin
          if (rsp_ready_i)
            state_q <= CTRL_IDLE;
        end
        default:
        begin
          state_q <= CTRL_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      op_q    <= req_op_i;
      addr_q  <= req_addr_i;
      write_q <= req_store;
      err_q   <= misaligned_i;
      word_q  <= (req_hit && !misaligned_i) ? hit_data_i : '0;
    end
    else if ((state_q == CTRL_BUS) && bus_done_i)
    begin
      err_q  <= bus_err_i;
      word_q <= write_q ? '0 : bus_rdata_i;
    end
  end

endmodule

`default_nettype wire

// File: source/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // funct3 in the low bits, store flag in bit 3
  localparam logic [3:0] LSU_OP_LB  = 4'h0;
  localparam logic [3:0] LSU_OP_LH  = 4'h1;
  localparam logic [3:0] LSU_OP_LW  = 4'h2;
  localparam logic [3:0] LSU_OP_LBU = 4'h4;
  localparam logic [3:0] LSU_OP_LHU = 4'h5;
  localparam logic [3:0] LSU_OP_SB  = 4'h8;
  localparam logic [3:0] LSU_OP_SH  = 4'h9;
  localparam logic [3:0] LSU_OP_SW  = 4'ha;

  localparam int L1D_IDX_W = 6;
  localparam int L1D_LINES = 64;
  localparam int L1D_TAG_W = 24;

  localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
  localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;
  localparam logic [1:0] AXI_RESP_DECERR = 2'b11;

  // request controller states
  localparam logic [1:0] CTRL_IDLE = 2'd0;
  localparam logic [1:0] CTRL_BUS  = 2'd1;
  localparam logic [1:0] CTRL_RESP = 2'd2;

  // fetched word seen as bytes or halfwords
  typedef union packed {
    logic [3:0][7:0]  b;
    logic [1:0][15:0] h;
  } load_word_u;

endpackage

`default_nettype wire

// File: source/lsu_sub.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_sub (
  input  wire                        clk,
  input  wire                        rst_n_i,
  input  wire                        req_valid_i,
  output logic                       req_ready_o,
  input  wire  [3:0]                 req_op_i,
  input  wire  [lsu_pkg::ADDR_W-1:0] req_addr_i,
  input  wire  [lsu_pkg::DATA_W-1:0] req_wdata_i,
  output logic                       rsp_valid_o,
  input  wire                        rsp_ready_i,
  output logic [lsu_pkg::DATA_W-1:0] rsp_rdata_o,
  output logic                       rsp_err_o,
  input  wire                        cache_en_i,
  output logic [lsu_pkg::ADDR_W-1:0] m_awaddr_o,
  output logic                       m_awvalid_o,
  input  wire                        m_awready_i,
  output logic [lsu_pkg::DATA_W-1:0] m_wdata_o,
  output logic [3:0]                 m_wstrb_o,
  output logic                       m_wvalid_o,
  input  wire                        m_wready_i,
  input  wire  [1:0]                 m_bresp_i,
  input  wire                        m_bvalid_i,
  output logic                       m_bready_o,
  output logic [lsu_pkg::ADDR_W-1:0] m_araddr_o,
  output logic                       m_arvalid_o,
  input  wire                        m_arready_i,
  input  wire  [lsu_pkg::DATA_W-1:0] m_rdata_i,
  input  wire  [1:0]                 m_rresp_i,
  input  wire                        m_rvalid_i,
  output logic                       m_rready_o
);
  import lsu_pkg::*;

  logic [ADDR_W-1:0] lookup_addr;
  logic              hit;
  logic [DATA_W-1:0] hit_data;
  logic              fill;
  logic              inval;
  logic [3:0]        align_op;
  logic [1:0]        align_addr_lo;
  logic              misaligned;
  logic [DATA_W-1:0] lane_data;
  logic [3:0]        strb;
  logic [DATA_W-1:0] rsp_word;
  logic              bus_start;
  logic              bus_write;
  logic [ADDR_W-1:0] bus_addr;
  logic              bus_done;
  logic [DATA_W-1:0] bus_rdata;
  logic              bus_err;

  lsu_ctrl lsu_ctrl_inst (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .req_op_i        (req_op_i),
    .req_addr_i      (req_addr_i),
    .rsp_valid_o     (rsp_valid_o),
    .rsp_ready_i     (rsp_ready_i),
    .rsp_word_o      (rsp_word),
    .rsp_err_o       (rsp_err_o),
    .cache_en_i      (cache_en_i),
    .lookup_addr_o   (lookup_addr),
    .hit_i           (hit),
    .hit_data_i      (hit_data),
    .fill_o          (fill),
    .inval_o         (inval),
    .misaligned_i    (misaligned),
    .align_op_o      (align_op),
    .align_addr_lo_o (align_addr_lo),
    .bus_start_o     (bus_start),
    .bus_write_o     (bus_write),
    .bus_addr_o      (bus_addr),
    .bus_done_i      (bus_done),
    .bus_rdata_i     (bus_rdata),
    .bus_err_i       (bus_err)
  );

  l1d_cache l1d_cache_inst (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .enable_i      (cache_en_i),
    .lookup_addr_i (lookup_addr),
    .fill_i        (fill),
    .fill_data_i   (bus_rdata),
    .inval_i       (inval),
    .hit_o         (hit),
    .hit_data_o    (hit_data)
  );

  // store data is only sampled in the accept cycle
  lsu_align lsu_align_inst (
    .op_i         (align_op),
    .addr_lo_i    (align_addr_lo),
    .store_data_i (req_wdata_i),
    .raw_word_i   (rsp_word),
    .lane_data_o  (lane_data),
    .strb_o       (strb),
    .misaligned_o (misaligned),
    .load_data_o  (rsp_rdata_o)
  );

  axil_master axil_master_inst (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .start_i     (bus_start),
    .write_i     (bus_write),
    .addr_i      (bus_addr),
    .wdata_i     (lane_data),
    .wstrb_i     (strb),
    .m_awaddr_o  (m_awaddr_o),
    .m_awvalid_o (m_awvalid_o),
    .m_awready_i (m_awready_i),
    .m_wdata_o   (m_wdata_o),
    .m_wstrb_o   (m_wstrb_o),
    .m_wvalid_o  (m_wvalid_o),
    .m_wready_i  (m_wready_i),
    .m_bresp_i   (m_bresp_i),
    .m_bvalid_i  (m_bvalid_i),
    .m_bready_o  (m_bready_o),
    .m_araddr_o  (m_araddr_o),
    .m_arvalid_o (m_arvalid_o),
    .m_arready_i (m_arready_i),
    .m_rdata_i   (m_rdata_i),
    .m_rresp_i   (m_rresp_i),
    .m_rvalid_i  (m_rvalid_i),
    .m_rready_o  (m_rready_o),
    .done_o      (bus_done),
    .rdata_o     (bus_rdata),
    .err_o       (bus_err)
  );

endmodule

`default_nettype wire

// File: verif/axil_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module axil_mem_model (
  input  wire         clk,
  input  wire         rst_n_i,
  input  wire  [31:0] awaddr_i,
  input  wire         awvalid_i,
  output logic        awready_o,
  input  wire  [31:0] wdata_i,
  input  wire  [3:0]  wstrb_i,
  input  wire         wvalid_i,
  output logic        wready_o,
  output logic [1:0]  bresp_o,
  output logic        bvalid_o,
  input  wire         bready_i,
  input  wire  [31:0] araddr_i,
  input  wire         arvalid_i,
  output logic        arready_o,
  output logic [31:0] rdata_o,
  output logic [1:0]  rresp_o,
  output logic        rvalid_o,
  input  wire         rready_i,
  output int          rd_count_o,
  output int          wr_count_o
);
  import lsu_pkg::*;

  localparam logic [31:0] ERR_BASE = 32'h800;

  logic [31:0] mem [256];
  logic [31:0] ar_addr, aw_addr, w_data;
  logic [3:0]  w_strb;
  logic        r_pend, b_pend, aw_done, w_done;
  int          ar_dly, aw_dly, w_dly, r_dly, b_dly;
  int          k;

  // each word holds its index times a fixed multiplier
  initial
  begin
    for (k = 0; k < 256; k++)
      mem[k] = k * 32'h01030507;
  end

  always @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      arready_o  <= 1'b0;
      rvalid_o   <= 1'b0;
      awready_o  <= 1'b0;
      wready_o   <= 1'b0;
      bvalid_o   <= 1'b0;
      rdata_o    <= '0;
      rresp_o    <= AXI_RESP_OKAY;
      bresp_o    <= AXI_RESP_OKAY;
      r_pend     <= 1'b0;
      b_pend     <= 1'b0;
      aw_done    <= 1'b0;
      w_done     <= 1'b0;
      ar_dly     <= 0;
      aw_dly     <= 0;
      w_dly      <= 0;
      rd_count_o <= 0;
      wr_count_o <= 0;
    end
    else
    begin
      // read address, then read data after a random gap
      if (arvalid_i && arready_o)
      begin
        arready_o  <= 1'b0;
        ar_addr    <= araddr_i;
        r_pend     <= 1'b1;
        r_dly      <= $urandom % 4;
        ar_dly     <= $urandom % 4;
        rd_count_o <= rd_count_o + 1;
      end
      else if (arvalid_i && !r_pend && !rvalid_o)
      begin
        if (ar_dly == 0)
          arready_o <= 1'b1;
        else
          ar_dly <= ar_dly - 1;
      end
      if (r_pend)
      begin
        if (r_dly == 0)
        begin
          r_pend   <= 1'b0;
          rvalid_o <= 1'b1;
          rdata_o  <= (ar_addr >= ERR_BASE) ? 32'h0 : mem[ar_addr[9:2]];
          rresp_o  <= (ar_addr >= ERR_BASE) ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
        end
        else
          r_dly <= r_dly - 1;
      end
      if (rvalid_o && rready_i)
        rvalid_o <= 1'b0;

      // write address and data are taken independently
      if (awvalid_i && awready_o)
      begin
        awready_o <= 1'b0;
        aw_addr   <= awaddr_i;
        aw_done   <= 1'b1;
        aw_dly    <= $urandom % 4;
      end
      else if (awvalid_i && !aw_done)
      begin
        if (aw_dly == 0)
          awready_o <= 1'b1;
        else
          aw_dly <= aw_dly - 1;
      end
      if (wvalid_i && wready_o)
      begin
        wready_o <= 1'b0;
        w_data   <= wdata_i;
        w_strb   <= wstrb_i;
        w_done   <= 1'b1;
        w_dly    <= $urandom % 4;
      end
      else if (wvalid_i && !w_done)
      begin
        if (w_dly == 0)
          wready_o <= 1'b1;
        else
          w_dly <= w_dly - 1;
      end
      if (aw_done && w_done && !b_pend && !bvalid_o)
      begin
        aw_done    <= 1'b0;
        w_done     <= 1'b0;
        b_pend     <= 1'b1;
        b_dly      <= $urandom % 4;
        wr_count_o <= wr_count_o + 1;
        if (aw_addr < ERR_BASE)
        begin
          for (k = 0; k < 4; k++)
            if (w_strb[k])
              mem[aw_addr[9:2]][k*8 +: 8] <= w_data[k*8 +: 8];
        end
      end
      if (b_pend)
      begin
        if (b_dly == 0)
        begin
          b_pend   <= 1'b0;
          bvalid_o <= 1'b1;
          bresp_o  <= (aw_addr >= ERR_BASE) ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
        end
        else
          b_dly <= b_dly - 1;
      end
      if (bvalid_o && bready_i)
        bvalid_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: verif/lsu_checker.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_checker (
  input  wire         clk,
  input  wire         rst_n_i,
  input  wire         req_valid_i,
  input  wire         req_ready_i,
  input  wire  [3:0]  req_op_i,
  input  wire  [31:0] req_addr_i,
  input  wire         rsp_valid_i,
  input  wire         rsp_ready_i,
  input  wire  [31:0] rsp_rdata_i,
  input  wire         rsp_err_i,
  input  wire  [31:0] exp_data_i,
  input  wire         exp_err_i,
  input  wire         exp_rd_i,
  input  wire         exp_wr_i,
  input  wire  [31:0] rd_count_i,
  input  wire  [31:0] wr_count_i,
  output int          done_cnt_o,
  output int          fail_cnt_o
);

  logic [31:0] exp_data, held_data, cur_addr;
  logic [3:0]  cur_op;
  logic        exp_err, exp_rd, exp_wr, held_err, holding, bad;
  int          rd_base, wr_base;

  task automatic compare_field(input string name, input logic [31:0] expv,
                               input logic [31:0] gotv);
    if (expv !== gotv)
    begin
      $display("[ERROR] %0t %s expected %h got %h", $time, name, expv, gotv);
      bad = 1'b1;
    end
  endtask

  initial
  begin
    done_cnt_o = 0;
    fail_cnt_o = 0;
  end

  always @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      holding = 1'b0;
      bad     = 1'b0;
    end
    else
    begin
      if (req_valid_i && req_ready_i)
      begin
        cur_op   = req_op_i;
        cur_addr = req_addr_i;
        exp_data = exp_data_i;
        exp_err  = exp_err_i;
        exp_rd   = exp_rd_i;
        exp_wr   = exp_wr_i;
        rd_base  = rd_count_i;
        wr_base  = wr_count_i;
        bad      = 1'b0;
      end
      // a stalled response must not move
      if (holding)
      begin
        if (!rsp_valid_i)
        begin
          $display("response withdrawn before rsp_ready_i at %0t", $time);
          bad = 1'b1;
        end
        else
        begin
          compare_field("rsp_rdata_o (stall)", held_data, rsp_rdata_i);
          compare_field("rsp_err_o (stall)", {31'b0, held_err}, {31'b0, rsp_err_i});
        end
      end
      if (rsp_valid_i && rsp_ready_i)
      begin
        holding = 1'b0;
        compare_field("rsp_rdata_o", exp_data, rsp_rdata_i);
        compare_field("rsp_err_o", {31'b0, exp_err}, {31'b0, rsp_err_i});
        compare_field("bus reads", {31'b0, exp_rd}, rd_count_i - rd_base);
        compare_field("bus writes", {31'b0, exp_wr}, wr_count_i - wr_base);
        if (bad)
        begin
          $display("case %0d op %h addr %h: mismatch", done_cnt_o, cur_op, cur_addr);
          fail_cnt_o = fail_cnt_o + 1;
        end
        else
          $display("case %0d op %h addr %h: ok", done_cnt_o, cur_op, cur_addr);
        done_cnt_o = done_cnt_o + 1;
      end
      else if (rsp_valid_i)
      begin
        holding   = 1'b1;
        held_data = rsp_rdata_i;
        held_err  = rsp_err_i;
      end
      else
        holding = 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: verif/lsu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_tb;
  import lsu_pkg::*;

  localparam int MAX_TESTS    = 64;
  localparam int RESET_CYCLES = 10;

  logic        clk, rst_n, req_valid, req_ready, rsp_valid, rsp_ready, rsp_err, cache_en;
  logic [3:0]  req_op;
  logic [31:0] req_addr, req_wdata, rsp_rdata;
  logic [31:0] awaddr, wdata, araddr, rdata;
  logic [3:0]  wstrb;
  logic [1:0]  bresp, rresp;
  logic        awvalid, awready, wvalid, wready, bvalid, bready;
  logic        arvalid, arready, rvalid, rready;
  logic [31:0] exp_data;
  logic        exp_err, exp_rd, exp_wr;
  int          rd_count, wr_count, done_cnt, fail_cnt;

  // stimulus and expected values
  logic [3:0]  t_op   [MAX_TESTS];
  logic [31:0] t_addr [MAX_TESTS];
  logic [31:0] t_wdat [MAX_TESTS];
  logic        t_en   [MAX_TESTS];
  logic [31:0] t_exp  [MAX_TESTS];
  logic        t_err  [MAX_TESTS];
  logic        t_rd   [MAX_TESTS];
  logic        t_wr   [MAX_TESTS];
  logic [31:0] ref_mem [256];
  int          n_tests;

  lsu_sub lsu_sub_inst (
    .clk (clk), .rst_n_i (rst_n),
    .req_valid_i (req_valid), .req_ready_o (req_ready), .req_op_i (req_op),
    .req_addr_i (req_addr), .req_wdata_i (req_wdata),
    .rsp_valid_o (rsp_valid), .rsp_ready_i (rsp_ready), .rsp_rdata_o (rsp_rdata),
    .rsp_err_o (rsp_err), .cache_en_i (cache_en),
    .m_awaddr_o (awaddr), .m_awvalid_o (awvalid), .m_awready_i (awready),
    .m_wdata_o (wdata), .m_wstrb_o (wstrb), .m_wvalid_o (wvalid), .m_wready_i (wready),
    .m_bresp_i (bresp), .m_bvalid_i (bvalid), .m_bready_o (bready),
    .m_araddr_o (araddr), .m_arvalid_o (arvalid), .m_arready_i (arready),
    .m_rdata_i (rdata), .m_rresp_i (rresp), .m_rvalid_i (rvalid), .m_rready_o (rready)
  );

  axil_mem_model mem_inst (
    .clk (clk), .rst_n_i (rst_n),
    .awaddr_i (awaddr), .awvalid_i (awvalid), .awready_o (awready),
    .wdata_i (wdata), .wstrb_i (wstrb), .wvalid_i (wvalid), .wready_o (wready),
    .bresp_o (bresp), .bvalid_o (bvalid), .bready_i (bready),
    .araddr_i (araddr), .arvalid_i (arvalid), .arready_o (arready),
    .rdata_o (rdata), .rresp_o (rresp), .rvalid_o (rvalid), .rready_i (rready),
    .rd_count_o (rd_count), .wr_count_o (wr_count)
  );

  lsu_checker checker_inst (
    .clk (clk), .rst_n_i (rst_n),
    .req_valid_i (req_valid), .req_ready_i (req_ready), .req_op_i (req_op),
    .req_addr_i (req_addr), .rsp_valid_i (rsp_valid), .rsp_ready_i (rsp_ready),
    .rsp_rdata_i (rsp_rdata), .rsp_err_i (rsp_err),
    .exp_data_i (exp_data), .exp_err_i (exp_err), .exp_rd_i (exp_rd), .exp_wr_i (exp_wr),
    .rd_count_i (rd_count), .wr_count_i (wr_count),
    .done_cnt_o (done_cnt), .fail_cnt_o (fail_cnt)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // byte or halfword pick, then sign or zero extension
  function automatic logic [31:0] extract_load(input logic [3:0] op, input logic [1:0] lo,
                                               input logic [31:0] raw);
    load_word_u  w;
    logic [7:0]  b;
    logic [15:0] h;
    w = raw;
    b = w.b[lo];
    h = w.h[lo[1]];
    case (op)
      LSU_OP_LB:  return {{24{b[7]}}, b};
      LSU_OP_LBU: return {24'h0, b};
      LSU_OP_LH:  return {{16{h[15]}}, h};
      LSU_OP_LHU: return {16'h0, h};
      default:    return raw;
    endcase
  endfunction

  task automatic add_test(input logic [3:0] op, input logic [31:0] addr,
                          input logic [31:0] data, input logic en, input logic rd);
    logic        is_store;
    logic        mis;
    logic        slverr;
    is_store = op[3];
    slverr   = (addr >= 32'h800);
    case (op)
      LSU_OP_LH, LSU_OP_LHU, LSU_OP_SH: mis = addr[0];
      LSU_OP_LW, LSU_OP_SW:             mis = (addr[1:0] != 2'b00);
      default:                          mis = 1'b0;
    endcase
    t_op[n_tests]   = op;
    t_addr[n_tests] = addr;
    t_wdat[n_tests] = data;
    t_en[n_tests]   = en;
    t_err[n_tests]  = mis || slverr;
    t_rd[n_tests]   = (mis || is_store) ? 1'b0 : rd;
    t_wr[n_tests]   = is_store && !mis;
    if (is_store || mis || slverr)
      t_exp[n_tests] = 32'h0;
    else
      t_exp[n_tests] = extract_load(op, addr[1:0], ref_mem[addr[9:2]]);
    // only the addressed byte or halfword of the word changes
    if (is_store && !mis && !slverr)
    begin
      case (op)
        LSU_OP_SB: ref_mem[addr[9:2]][addr[1:0]*8 +: 8] = data[7:0];
        LSU_OP_SH: ref_mem[addr[9:2]][addr[1]*16 +: 16] = data[15:0];
        default:   ref_mem[addr[9:2]] = data;
      endcase
    end
    n_tests++;
  endtask

  task automatic build_table();
    // widths and signs, cache off
    add_test(LSU_OP_LW,  32'h010, 0, 1'b0, 1'b1);
    add_test(LSU_OP_LB,  32'h013, 0, 1'b0, 1'b1);
    add_test(LSU_OP_LBU, 32'h013, 0, 1'b0, 1'b1);
    add_test(LSU_OP_LH,  32'h012, 0, 1'b0, 1'b1);
    add_test(LSU_OP_LHU, 32'h012, 0, 1'b0, 1'b1);
    add_test(LSU_OP_LB,  32'h200, 0, 1'b0, 1'b1);
    add_test(LSU_OP_LBU, 32'h200, 0, 1'b0, 1'b1);
    add_test(LSU_OP_LB,  32'h201, 0, 1'b0, 1'b1);
    add_test(LSU_OP_LH,  32'h202, 0, 1'b0, 1'b1);
    add_test(LSU_OP_LHU, 32'h202, 0, 1'b0, 1'b1);
    // stores merged under the strobe
    add_test(LSU_OP_SB,  32'h041, 32'h000000aa, 1'b0, 1'b0);
    add_test(LSU_OP_SH,  32'h042, 32'h0000beef, 1'b0, 1'b0);
    add_test(LSU_OP_LW,  32'h040, 0, 1'b0, 1'b1);
    add_test(LSU_OP_SB,  32'h047, 32'h1234565a, 1'b0, 1'b0);
    add_test(LSU_OP_LW,  32'h044, 0, 1'b0, 1'b1);
    add_test(LSU_OP_SW,  32'h048, 32'h12345678, 1'b0, 1'b0);
    add_test(LSU_OP_LW,  32'h048, 0, 1'b0, 1'b1);
    add_test(LSU_OP_SH,  32'h04c, 32'h1234abcd, 1'b0, 1'b0);
    add_test(LSU_OP_LHU, 32'h04c, 0, 1'b0, 1'b1);
    // hits with the cache on
    add_test(LSU_OP_LW,  32'h020, 0, 1'b1, 1'b1);
    add_test(LSU_OP_LW,  32'h020, 0, 1'b1, 1'b0);
    add_test(LSU_OP_LH,  32'h022, 0, 1'b1, 1'b0);
    // store invalidates, then index conflict
    add_test(LSU_OP_SW,  32'h020, 32'hcafef00d, 1'b1, 1'b0);
    add_test(LSU_OP_LW,  32'h020, 0, 1'b1, 1'b1);
    add_test(LSU_OP_LW,  32'h020, 0, 1'b1, 1'b0);
    add_test(LSU_OP_LW,  32'h120, 0, 1'b1, 1'b1);
    add_test(LSU_OP_LW,  32'h020, 0, 1'b1, 1'b1);
    // misaligned and error window
    add_test(LSU_OP_LH,  32'h031, 0, 1'b1, 1'b0);
    add_test(LSU_OP_LW,  32'h032, 0, 1'b1, 1'b0);
    add_test(LSU_OP_SW,  32'h036, 32'h55555555, 1'b1, 1'b0);
    add_test(LSU_OP_LW,  32'h800, 0, 1'b1, 1'b1);
    add_test(LSU_OP_LW,  32'h800, 0, 1'b1, 1'b1);
    add_test(LSU_OP_SW,  32'h804, 32'h0badf00d, 1'b1, 1'b0);
  endtask

  // watchdog
  initial
  begin
    #1;
    repeat (n_tests * 40 + RESET_CYCLES) @(posedge clk);
    $display("timeout: %0d of %0d responses seen", done_cnt, n_tests);
    $display("test failed");
    $finish;
  end

  initial
  begin
    int i;
    void'($urandom(39919));
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req_op    = '0;
    req_addr  = '0;
    req_wdata = '0;
    rsp_ready = 1'b0;
    cache_en  = 1'b0;
    exp_data  = '0;
    exp_err   = 1'b0;
    exp_rd    = 1'b0;
    exp_wr    = 1'b0;
    n_tests   = 0;
    for (i = 0; i < 256; i++)
      ref_mem[i] = i * 32'h01030507;
    build_table();
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (i = 0; i < n_tests; i++)
    begin
      @(negedge clk);
      while (!req_ready)
        @(negedge clk);
      req_op    = t_op[i];
      req_addr  = t_addr[i];
      req_wdata = t_wdat[i];
      cache_en  = t_en[i];
      exp_data  = t_exp[i];
      exp_err   = t_err[i];
      exp_rd    = t_rd[i];
      exp_wr    = t_wr[i];
      req_valid = 1'b1;
      @(negedge clk);
      req_valid = 1'b0;
      // random back-pressure on the response
      while (done_cnt == i)
      begin
        rsp_ready = ($urandom % 4) != 0;
        @(negedge clk);
      end
      rsp_ready = 1'b0;
    end
    @(negedge clk);
    $display("responses %0d of %0d, mismatches %0d", done_cnt, n_tests, fail_cnt);
    if (fail_cnt == 0 && done_cnt == n_tests)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire
